// File: conv_line_buffer_top.f
hw/conv_pkg.sv
hw/row_buffer_mem.sv
hw/slab_mem.sv
hw/conv_buffers_xbar.sv
hw/row_window_seq.sv
hw/conv_line_buffer_top.sv
verif/conv_line_buffer_props.sv
verif/conv_line_buffer_tb.sv

// File: verif/conv_line_buffer_tb.sv
`timescale 1ns/1ps

module conv_line_buffer_tb;
  import conv_pkg::*;

  localparam int pixels_in_row = 32;
  localparam int mem_depth = 64;
  localparam int pw = pixels_in_row * 8;

  // one expected window, slabs skipped while slab banks hold unknown data
  // due is the clock count at which the checker must see the window
  typedef struct packed {
    logic [2:0][pw-1:0] rows;
    logic [2:0][15:0] slabs;
    logic chk_slab;
    int due;
  } exp_win_t;

  logic clk;
  logic reset;
  win_cmd_t win_cmd;
  buf_wr_req_t buf_wr;
  logic [pw-1:0] win_row0, win_row1, win_row2;
  logic [15:0] win_slab0, win_slab1, win_slab2;
  logic win_valid;
  logic [2:0][pw-1:0] win_rows;
  logic [2:0][15:0] win_slabs;

  // reference model, index k is bank k + 1
  logic [511:0] mbuf [3][mem_depth];
  logic [15:0] mslab [3][mem_depth];
  exp_win_t exp_q[$];
  logic slab_known;
  logic [31:0] rng;

  // rising edges seen so far
  int cycle_n;

  // write-back of the last command, lands after the following command reads
  logic pend_valid;
  int pend_adr;
  logic [15:0] pend_data [3];

  conv_line_buffer_top #(.pixels_in_row(pixels_in_row), .mem_depth(mem_depth)) dut0 (.*);

  assign win_rows = {win_row2, win_row1, win_row0};
  assign win_slabs = {win_slab2, win_slab1, win_slab0};

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_n <= cycle_n + 1;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % n);
  endfunction

  function automatic logic [511:0] rand_word();
    logic [511:0] w;
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      w[i*32 +: 32] = rng;
    end
    return w;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic apply_pending();
    if (pend_valid) begin
      for (int k = 0; k < 3; k++) begin
        mslab[k][pend_adr] = pend_data[k];
      end
    end
    pend_valid = 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    win_cmd <= '0;
    buf_wr <= '0;
    apply_pending();
  endtask

  task automatic load_word(input int k, input int adr, input logic [511:0] word);
    buf_wr_req_t w;
    w.en = 1'b1;
    w.idx = bank_idx_t'(k + 1);
    w.adr = adr_w'(adr);
    w.word.raw = word;
    @(posedge clk);
    win_cmd <= '0;
    buf_wr <= w;
    mbuf[k][adr] = word;
    apply_pending();
  endtask

  // expected rows come from bank ((i + rot) mod 3) + 1 at adr
  task automatic issue_window(input int adr, input logic ws, input int rot);
    win_cmd_t c;
    exp_win_t e;
    int k;
    logic [pw-1:0] h;
    logic [15:0] lead [3];
    c.valid = 1'b1;
    c.adr = adr_w'(adr);
    c.word_select = ws;
    c.rot = 2'(rot);
    e.chk_slab = slab_known;
    for (int i = 0; i < 3; i++) begin
      k = (i + rot) % 3;
      h = ws ? mbuf[k][adr][2*pw-1:pw] : mbuf[k][adr][pw-1:0];
      e.rows[i] = h;
      e.slabs[i] = mslab[k][adr];
      lead[k] = h[pw-1 -: 16];
    end
    @(posedge clk);
    buf_wr <= '0;
    win_cmd <= c;
    apply_pending();
    pend_valid = 1'b1;
    pend_adr = (adr + 1) % mem_depth;
    pend_data = lead;
    // sampled one edge after driving, win_valid three edges later,
    // seen by the checker on the edge after that
    e.due = cycle_n + 4;
    exp_q.push_back(e);
  endtask

  task automatic check_idle();
    @(posedge clk);
    assert (!win_valid && win_rows == '0 && win_slabs == '0)
      else stop_on_error($sformatf("mismatch at %0t: window outputs active while idle", $time));
    assert ({dut0.buf1_wr_en, dut0.buf2_wr_en, dut0.buf3_wr_en,
             dut0.slab1_wr_en, dut0.slab2_wr_en, dut0.slab3_wr_en} == '0)
      else stop_on_error("a bank write enable was seen with no load or command");
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      idle_cycle();
      n++;
      if (n > 10) begin
        stop_on_error("timed out waiting for the outstanding windows");
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // window checker, outputs sampled on the edge that sees win_valid
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    exp_win_t e;
    if (!reset && win_valid) begin
      assert (exp_q.size() > 0)
        else stop_on_error("window valid pulse with no command in flight");
      e = exp_q.pop_front();
      assert (cycle_n == e.due)
        else stop_on_error($sformatf("mismatch at %0t: window in cycle %0d, expected cycle %0d",
                                     $time, cycle_n, e.due));
      for (int r = 0; r < 3; r++) begin
        assert (win_rows[r] == e.rows[r])
          else stop_on_error($sformatf("mismatch at %0t: row %0d pixels %h, expected %h",
                                       $time, r, win_rows[r], e.rows[r]));
        if (e.chk_slab) begin
          assert (win_slabs[r] == e.slabs[r])
            else stop_on_error($sformatf("mismatch at %0t: row %0d slab %h, expected %h",
                                         $time, r, win_slabs[r], e.slabs[r]));
        end
      end
    end
  end

  // bound crossbar checker, any failed property ends the run
  always @(posedge clk) begin
    if (dut0.xbar0.props0.fail_count != 0) begin
      stop_on_error("a crossbar property failed");
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    int a;
    logic ws;
    clk = 1'b0;
    reset = 1'b1;
    win_cmd = '0;
    buf_wr = '0;
    rng = 32'd84227;
    cycle_n = 0;
    slab_known = 1'b0;
    pend_valid = 1'b0;
    pend_adr = 0;
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < mem_depth; j++) begin
        mbuf[k][j] = '0;
        mslab[k][j] = '0;
      end
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (8) check_idle();
    // zero all buffer words, then sweep every column to clear the slabs
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < mem_depth; j++) begin
        load_word(k, j, '0);
      end
    end
    for (int j = 0; j < mem_depth; j++) begin
      issue_window(j, 1'b0, 0);
    end
    drain();
    slab_known = 1'b1;
    // slab before any data write-back reads the cleared value
    issue_window(9, 1'b1, 2);
    drain();
    // random rows in every bank
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < mem_depth; j++) begin
        load_word(k, j, rand_word());
      end
    end
    idle_cycle();
    // each rotation on its own
    for (int rot = 0; rot < 3; rot++) begin
      issue_window(rand_below(mem_depth), rand_below(2) != 0, rot);
      idle_cycle();
    end
    drain();
    // slab carry from column a into column a + 1
    for (int rot = 0; rot < 3; rot++) begin
      a = rand_below(mem_depth - 1);
      ws = rand_below(2) != 0;
      issue_window(a, ws, rot);
      idle_cycle();
      issue_window(a + 1, ws, rot);
      idle_cycle();
    end
    drain();
    // back-to-back commands, three windows in flight
    repeat (40) begin
      issue_window(rand_below(mem_depth), rand_below(2) != 0, rand_below(3));
    end
    drain();
    if (dut0.xbar0.props0.fail_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_error("a crossbar property failed during the run");
    end
  end

endmodule

// File: verif/conv_line_buffer_props.sv
`timescale 1ns/1ps

module conv_line_buffer_props (
  input logic clk,
  input logic reset,
  input conv_pkg::row_req_t req0, req1, req2,
  input logic [2:0] buf_rd_en, slab_rd_en, buf_wr_en, slab_wr_en
);
  import conv_pkg::*;

  // failed assertions so far
  int fail_count = 0;

  // each valid row claims its own bank, so no bank has two sources
  property rows_use_distinct_banks;
    @(posedge clk) disable iff (reset)
      req0.valid |-> (req0.buf_idx != req1.buf_idx) && (req0.buf_idx != req2.buf_idx)
                     && (req1.buf_idx != req2.buf_idx);
  endproperty

  // registered strobes and routed reads are all clear one cycle after reset
  property quiet_after_reset;
    @(posedge clk)
      reset |=> (buf_rd_en == '0) && (slab_rd_en == '0) && (buf_wr_en == '0)
                && (slab_wr_en == '0);
  endproperty

  // write-back of the leading pixels one cycle behind the buffer read
  property slab_write_follows_read;
    @(posedge clk) disable iff (reset)
      (buf_rd_en != '0) |=> (slab_wr_en == $past(buf_rd_en));
  endproperty

  assert property (rows_use_distinct_banks)
    else begin
      fail_count++;
      $error("two row requests name the same buffer bank");
    end

  assert property (quiet_after_reset)
    else begin
      fail_count++;
      $error("bank enable active in the cycle after reset");
    end

  assert property (slab_write_follows_read)
    else begin
      fail_count++;
      $error("slab write enable does not follow the buffer read");
    end

endmodule

bind conv_buffers_xbar conv_line_buffer_props props0 (.*);

// File: hw/conv_line_buffer_top.sv
`timescale 1ns/1ps

module conv_line_buffer_top #(
  parameter int pixels_in_row = 32,
  parameter int mem_depth = 64
) (
  input  logic clk,
  input  logic reset,
  input  conv_pkg::win_cmd_t win_cmd,
  input  conv_pkg::buf_wr_req_t buf_wr,
  output logic [pixels_in_row*8-1:0] win_row0, win_row1, win_row2,
  output logic [15:0] win_slab0, win_slab1, win_slab2,
  output logic win_valid
);
  import conv_pkg::*;

  // sequencer to crossbar
  row_req_t req0, req1, req2;
  bank_idx_t last_buf_idx0, last_buf_idx1, last_buf_idx2;
  bank_idx_t last_slab_idx0, last_slab_idx1, last_slab_idx2;

  // crossbar to buffer banks
  logic [adr_w-1:0] buf1_rd_adr, buf2_rd_adr, buf3_rd_adr;
  logic buf1_rd_word_select, buf2_rd_word_select, buf3_rd_word_select;
  logic buf1_rd_en, buf2_rd_en, buf3_rd_en;
  logic [pixels_in_row*8-1:0] buf1_rd_pixels, buf2_rd_pixels, buf3_rd_pixels;
  logic [adr_w-1:0] buf1_wr_adr, buf2_wr_adr, buf3_wr_adr;
  buf_word_u buf1_wr_word, buf2_wr_word, buf3_wr_word;
  logic buf1_wr_en, buf2_wr_en, buf3_wr_en;

  // crossbar to slab banks
  logic [adr_w-1:0] slab1_rd_adr, slab2_rd_adr, slab3_rd_adr;
  logic slab1_rd_en, slab2_rd_en, slab3_rd_en;
  logic [15:0] slab1_rd_data, slab2_rd_data, slab3_rd_data;
  logic [adr_w-1:0] slab1_wr_adr, slab2_wr_adr, slab3_wr_adr;
  logic [15:0] slab1_wr_data, slab2_wr_data, slab3_wr_data;
  logic slab1_wr_en, slab2_wr_en, slab3_wr_en;

  row_window_seq seq0 (.*);

  // ---------------------------------------------------------------------------
  // crossbar, window outputs renamed at the boundary
  // ---------------------------------------------------------------------------

  conv_buffers_xbar #(.pixels_in_row(pixels_in_row)) xbar0 (
    .*,
    .last_row0(win_row0), .last_row1(win_row1), .last_row2(win_row2),
    .last_slab0(win_slab0), .last_slab1(win_slab1), .last_slab2(win_slab2)
  );

  // ---------------------------------------------------------------------------
  // bank 1 to 3 memories
  // ---------------------------------------------------------------------------

  row_buffer_mem #(.pixels_in_row(pixels_in_row), .mem_depth(mem_depth)) buf_mem1 (
    .clk(clk), .wr_en(buf1_wr_en), .wr_adr(buf1_wr_adr), .wr_word(buf1_wr_word),
    .rd_en(buf1_rd_en), .rd_adr(buf1_rd_adr), .rd_word_select(buf1_rd_word_select),
    .rd_pixels(buf1_rd_pixels)
  );

  row_buffer_mem #(.pixels_in_row(pixels_in_row), .mem_depth(mem_depth)) buf_mem2 (
    .clk(clk), .wr_en(buf2_wr_en), .wr_adr(buf2_wr_adr), .wr_word(buf2_wr_word),
    .rd_en(buf2_rd_en), .rd_adr(buf2_rd_adr), .rd_word_select(buf2_rd_word_select),
    .rd_pixels(buf2_rd_pixels)
  );

  row_buffer_mem #(.pixels_in_row(pixels_in_row), .mem_depth(mem_depth)) buf_mem3 (
    .clk(clk), .wr_en(buf3_wr_en), .wr_adr(buf3_wr_adr), .wr_word(buf3_wr_word),
    .rd_en(buf3_rd_en), .rd_adr(buf3_rd_adr), .rd_word_select(buf3_rd_word_select),
    .rd_pixels(buf3_rd_pixels)
  );

  slab_mem #(.mem_depth(mem_depth)) slab_mem1 (
    .clk(clk), .wr_en(slab1_wr_en), .wr_adr(slab1_wr_adr), .wr_data(slab1_wr_data),
    .rd_en(slab1_rd_en), .rd_adr(slab1_rd_adr), .rd_data(slab1_rd_data)
  );

  slab_mem #(.mem_depth(mem_depth)) slab_mem2 (
    .clk(clk), .wr_en(slab2_wr_en), .wr_adr(slab2_wr_adr), .wr_data(slab2_wr_data),
    .rd_en(slab2_rd_en), .rd_adr(slab2_rd_adr), .rd_data(slab2_rd_data)
  );

  slab_mem #(.mem_depth(mem_depth)) slab_mem3 (
    .clk(clk), .wr_en(slab3_wr_en), .wr_adr(slab3_wr_adr), .wr_data(slab3_wr_data),
    .rd_en(slab3_rd_en), .rd_adr(slab3_rd_adr), .rd_data(slab3_rd_data)
  );

endmodule

// File: hw/row_window_seq.sv
`timescale 1ns/1ps

module row_window_seq (
  input  logic clk,
  input  logic reset,
  input  conv_pkg::win_cmd_t win_cmd,
  output conv_pkg::row_req_t req0, req1, req2,
  output conv_pkg::bank_idx_t last_buf_idx0, last_buf_idx1, last_buf_idx2,
  output conv_pkg::bank_idx_t last_slab_idx0, last_slab_idx1, last_slab_idx2,
  output logic win_valid
);
  import conv_pkg::*;

  row_req_t [2:0] req_next, req_q;
  bank_idx_t [2:0] last_buf_q, last_slab_q;
  logic valid_d2, valid_d3;

  // bank ((row + rot) mod 3) + 1
  function automatic bank_idx_t rot_bank(input int row, input logic [1:0] rot);
    int sum;
    sum = row + int'(rot);
    if (sum >= 3) begin
      sum = sum - 3;
    end
    return bank_idx_t'(sum + 1);
  endfunction

  // idle cycles give all-zero requests, so no bank is named
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      req_next[i] = '0;
      if (win_cmd.valid) begin
        req_next[i].adr = win_cmd.adr;
        req_next[i].word_select = win_cmd.word_select;
        req_next[i].buf_idx = rot_bank(i, win_cmd.rot);
        // slab of a row lives in the same bank number as its buffer
        req_next[i].slab_adr = win_cmd.adr;
        req_next[i].slab_idx = rot_bank(i, win_cmd.rot);
        req_next[i].slab_adr_to_wr = win_cmd.adr + adr_w'(1);
        req_next[i].valid = 1'b1;
      end
    end
  end

  // cycle 1 requests, cycle 2 return indices, cycle 3 window valid
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
      last_buf_q <= '0;
      last_slab_q <= '0;
      valid_d2 <= 1'b0;
      valid_d3 <= 1'b0;
    end else begin
      req_q <= req_next;
      for (int i = 0; i < 3; i++) begin
        last_buf_q[i] <= req_q[i].buf_idx;
        last_slab_q[i] <= req_q[i].slab_idx;
      end
      valid_d2 <= req_q[0].valid;
      valid_d3 <= valid_d2;
    end
  end

  assign {req2, req1, req0} = req_q;
  assign {last_buf_idx2, last_buf_idx1, last_buf_idx0} = last_buf_q;
  assign {last_slab_idx2, last_slab_idx1, last_slab_idx0} = last_slab_q;
  assign win_valid = valid_d3;

endmodule

// File: hw/conv_buffers_xbar.sv
`timescale 1ns/1ps

module conv_buffers_xbar #(
  parameter int pixels_in_row = 32
) (
  input  logic clk,
  input  logic reset,
  // cycle 1 row requests and cycle 2 return indices
  input  conv_pkg::row_req_t req0, req1, req2,
  input  conv_pkg::bank_idx_t last_buf_idx0, last_buf_idx1, last_buf_idx2,
  input  conv_pkg::bank_idx_t last_slab_idx0, last_slab_idx1, last_slab_idx2,
  input  conv_pkg::buf_wr_req_t buf_wr,
  // buffer bank read side
  output logic [conv_pkg::adr_w-1:0] buf1_rd_adr, buf2_rd_adr, buf3_rd_adr,
  output logic buf1_rd_word_select, buf2_rd_word_select, buf3_rd_word_select,
  output logic buf1_rd_en, buf2_rd_en, buf3_rd_en,
  input  logic [pixels_in_row*8-1:0] buf1_rd_pixels, buf2_rd_pixels, buf3_rd_pixels,
  // buffer bank write side
  output logic [conv_pkg::adr_w-1:0] buf1_wr_adr, buf2_wr_adr, buf3_wr_adr,
  output conv_pkg::buf_word_u buf1_wr_word, buf2_wr_word, buf3_wr_word,
  output logic buf1_wr_en, buf2_wr_en, buf3_wr_en,
  // slab bank read side
  output logic [conv_pkg::adr_w-1:0] slab1_rd_adr, slab2_rd_adr, slab3_rd_adr,
  output logic slab1_rd_en, slab2_rd_en, slab3_rd_en,
  input  logic [15:0] slab1_rd_data, slab2_rd_data, slab3_rd_data,
  // slab bank write side
  output logic [conv_pkg::adr_w-1:0] slab1_wr_adr, slab2_wr_adr, slab3_wr_adr,
  output logic [15:0] slab1_wr_data, slab2_wr_data, slab3_wr_data,
  output logic slab1_wr_en, slab2_wr_en, slab3_wr_en,
  // cycle 3 window
  output logic [pixels_in_row*8-1:0] last_row0, last_row1, last_row2,
  output logic [15:0] last_slab0, last_slab1, last_slab2
);
  import conv_pkg::*;

  localparam int pw = pixels_in_row * 8;

  // row side arrays, index r is row r
  row_req_t [2:0] req;
  bank_idx_t [2:0] last_buf_idx, last_slab_idx;
  logic [2:0][pw-1:0] last_row;
  logic [2:0][15:0] last_slab;

  // bank side arrays, index b serves bank b + 1
  logic [2:0][adr_w-1:0] buf_rd_adr, slab_rd_adr, slab_adr_to_wr;
  logic [2:0] buf_rd_word_select, buf_rd_en, slab_rd_en, slab_en_to_wr;
  logic [2:0] valid_buf_data, valid_slab_data;
  logic [2:0][pw-1:0] buf_rd_pixels, buf_data;
  logic [2:0][15:0] slab_rd_data, slab_data, slab_wr_data;
  logic [2:0][adr_w-1:0] slab_wr_adr, buf_wr_adr;
  logic [2:0] slab_wr_en, buf_wr_en;
  buf_word_u [2:0] buf_wr_word;

  assign req = {req2, req1, req0};
  assign last_buf_idx = {last_buf_idx2, last_buf_idx1, last_buf_idx0};
  assign last_slab_idx = {last_slab_idx2, last_slab_idx1, last_slab_idx0};
  assign buf_rd_pixels = {buf3_rd_pixels, buf2_rd_pixels, buf1_rd_pixels};
  assign slab_rd_data = {slab3_rd_data, slab2_rd_data, slab1_rd_data};

  assign {buf3_rd_adr, buf2_rd_adr, buf1_rd_adr} = buf_rd_adr;
  assign {buf3_rd_word_select, buf2_rd_word_select, buf1_rd_word_select} = buf_rd_word_select;
  assign {buf3_rd_en, buf2_rd_en, buf1_rd_en} = buf_rd_en;
  assign {buf3_wr_adr, buf2_wr_adr, buf1_wr_adr} = buf_wr_adr;
  assign {buf3_wr_word, buf2_wr_word, buf1_wr_word} = buf_wr_word;
  assign {buf3_wr_en, buf2_wr_en, buf1_wr_en} = buf_wr_en;
  assign {slab3_rd_adr, slab2_rd_adr, slab1_rd_adr} = slab_rd_adr;
  assign {slab3_rd_en, slab2_rd_en, slab1_rd_en} = slab_rd_en;
  assign {slab3_wr_adr, slab2_wr_adr, slab1_wr_adr} = slab_wr_adr;
  assign {slab3_wr_data, slab2_wr_data, slab1_wr_data} = slab_wr_data;
  assign {slab3_wr_en, slab2_wr_en, slab1_wr_en} = slab_wr_en;
  assign {last_row2, last_row1, last_row0} = last_row;
  assign {last_slab2, last_slab1, last_slab0} = last_slab;

  // ---------------------------------------------------------------------------
  // cycle 1, route row requests to the banks they name
  // ---------------------------------------------------------------------------

  always_comb begin
    for (int b = 0; b < 3; b++) begin
      buf_rd_adr[b] = '0;
      buf_rd_word_select[b] = 1'b0;
      buf_rd_en[b] = 1'b0;
      slab_adr_to_wr[b] = '0;
      slab_en_to_wr[b] = 1'b0;
      slab_rd_adr[b] = '0;
      slab_rd_en[b] = 1'b0;
      // rows walked from the top so row 0 wins if two name one bank
      for (int r = 2; r >= 0; r--) begin
        if (req[r].buf_idx == bank_idx_t'(b + 1)) begin
          buf_rd_adr[b] = req[r].adr;
          buf_rd_word_select[b] = req[r].word_select;
          buf_rd_en[b] = req[r].valid;
          // write-back of the leading pixels follows the buffer bank
          slab_adr_to_wr[b] = req[r].slab_adr_to_wr;
          slab_en_to_wr[b] = req[r].valid;
        end
        if (req[r].slab_idx == bank_idx_t'(b + 1)) begin
          slab_rd_adr[b] = req[r].slab_adr;
          slab_rd_en[b] = req[r].valid;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // cycle 2, bank returns
  // ---------------------------------------------------------------------------

  // banks hold their last read, so data is zeroed unless a read was issued
  always_comb begin
    for (int b = 0; b < 3; b++) begin
      buf_data[b] = valid_buf_data[b] ? buf_rd_pixels[b] : '0;
      slab_data[b] = valid_slab_data[b] ? slab_rd_data[b] : '0;
      // top two pixels of the half become the next column's slab
      slab_wr_data[b] = buf_data[b][pw-1 -: 16];
    end
  end

  // window register, selected by the indices delayed in the sequencer
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      case (last_buf_idx[r])
        2'd1: last_row[r] <= buf_data[0];
        2'd2: last_row[r] <= buf_data[1];
        2'd3: last_row[r] <= buf_data[2];
        default: last_row[r] <= '0;
      endcase
      case (last_slab_idx[r])
        2'd1: last_slab[r] <= slab_data[0];
        2'd2: last_slab[r] <= slab_data[1];
        2'd3: last_slab[r] <= slab_data[2];
        default: last_slab[r] <= '0;
      endcase
    end
  end

  // read-valid flags, slab write strobe and address, load strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_buf_data <= '0;
      valid_slab_data <= '0;
      slab_wr_en <= '0;
      slab_wr_adr <= '1;
      buf_wr_en <= '0;
    end else begin
      valid_buf_data <= buf_rd_en;
      valid_slab_data <= slab_rd_en;
      slab_wr_en <= slab_en_to_wr;
      slab_wr_adr <= slab_adr_to_wr;
      for (int b = 0; b < 3; b++) begin
        buf_wr_en[b] <= buf_wr.en && (buf_wr.idx == bank_idx_t'(b + 1));
      end
    end
  end

  // load address and word steered to the named bank, others see zero
  always_ff @(posedge clk) begin
    for (int b = 0; b < 3; b++) begin
      if (buf_wr.idx == bank_idx_t'(b + 1)) begin
        buf_wr_adr[b] <= buf_wr.adr;
        buf_wr_word[b] <= buf_wr.word;
      end else begin
        buf_wr_adr[b] <= '0;
        buf_wr_word[b] <= '0;
      end
    end
  end

endmodule

// File: hw/slab_mem.sv
`timescale 1ns/1ps

module slab_mem #(
  parameter int mem_depth = 64
) (
  input  logic clk,
  input  logic wr_en,
  input  logic [conv_pkg::adr_w-1:0] wr_adr,
  input  logic [15:0] wr_data,
  input  logic rd_en,
  input  logic [conv_pkg::adr_w-1:0] rd_adr,
  output logic [15:0] rd_data
);

  localparam int aw = $clog2(mem_depth);

  // two 8-bit pixels per entry, one entry per column address
  logic [15:0] mem [mem_depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr[aw-1:0]] <= wr_data;
    end
  end

  // read before write on an address collision
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_adr[aw-1:0]];
    end
  end

endmodule

// File: hw/row_buffer_mem.sv
`timescale 1ns/1ps

module row_buffer_mem #(
  parameter int pixels_in_row = 32,
  parameter int mem_depth = 64
) (
  input  logic clk,
  input  logic wr_en,
  input  logic [conv_pkg::adr_w-1:0] wr_adr,
  input  conv_pkg::buf_word_u wr_word,
  input  logic rd_en,
  input  logic [conv_pkg::adr_w-1:0] rd_adr,
  input  logic rd_word_select,
  output logic [pixels_in_row*8-1:0] rd_pixels
);
  import conv_pkg::*;

  // only the low address bits reach the array
  localparam int aw = $clog2(mem_depth);

  buf_word_u mem [mem_depth];

  // whole word written in one cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_adr[aw-1:0]] <= wr_word;
    end
  end

  // registered read of one half, held while rd_en is low
  // a read to the word being written sees the old contents
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pixels <= mem[rd_adr[aw-1:0]].half[rd_word_select];
    end
  end

endmodule

// File: hw/conv_pkg.sv
package conv_pkg;

  // ---------------------------------------------------------------------------
  // addressing
  // ---------------------------------------------------------------------------

  // one word address width shared by buffer and slab banks
  localparam int adr_w = 16;

  // bank number, 0 is no bank, 1 to 3 name a bank
  typedef logic [1:0] bank_idx_t;

  // ---------------------------------------------------------------------------
  // data words
  // ---------------------------------------------------------------------------

  // buffer word, loaded as raw bits, read back one pixel half at a time
  // half[0] is the low 256 bits, half[1] the high 256 bits
  typedef union packed {
    logic [511:0] raw;
    logic [1:0][255:0] half;
  } buf_word_u;

  // ---------------------------------------------------------------------------
  // requests
  // ---------------------------------------------------------------------------

  // one row of a window, buffer and slab read plus slab write-back address
  typedef struct packed {
    logic [adr_w-1:0] adr;
    logic word_select;
    bank_idx_t buf_idx;
    logic [adr_w-1:0] slab_adr;
    bank_idx_t slab_idx;
    logic [adr_w-1:0] slab_adr_to_wr;
    logic valid;
  } row_req_t;

  // load of one whole buffer word into bank idx
  typedef struct packed {
    logic en;
    bank_idx_t idx;
    logic [adr_w-1:0] adr;
    buf_word_u word;
  } buf_wr_req_t;

  // window command, rot picks which bank feeds row 0
  typedef struct packed {
    logic valid;
    logic [adr_w-1:0] adr;
    logic word_select;
    logic [1:0] rot;
  } win_cmd_t;

endpackage
